// ==== cpc_mem.f ====
hw/cpc_pkg.sv
hw/rom_loader.sv
hw/mf2_unit.sv
hw/mem_mux.sv
hw/cpc_mem_top.sv
sim/cpc_mem_assert.sv
sim/tb_cpc_mem.sv

// ==== sim/tb_cpc_mem.sv ====
`default_nettype none
`timescale 1ns/1ps

module tb_cpc_mem import cpc_pkg::*; ();

    localparam logic [8:0] EXP_BASE = 9'h100;
    localparam int         RDIV     = 8;
    localparam int         TIMEOUT  = 20000;   // About 5x the whole run
    localparam logic [22:0] PROBE_A = 23'h012345;

    logic clk_48 = 1'b0;
    logic RESET;
    logic ioctl_download, ioctl_wr;
    logic [24:0] ioctl_addr;
    logic [7:0]  ioctl_dout, ioctl_index;
    logic [15:0] cpu_addr;
    logic [7:0]  cpu_dout;
    logic mem_rd, mem_wr, io_wr, m1, key_nmi;
    logic [MEM_AW-1:0] ram_a;
    wire  [7:0] cpu_din;
    wire  mf2_nmi;
    wire  [MEM_AW-1:0] sdram_addr;
    wire  [1:0] sdram_bank;
    wire  sdram_we, sdram_oe;
    wire  [7:0] sdram_din;
    logic [7:0] sdram_dout;
    wire  [255:0] rom_map;

    integer seed = 32'h9660_78ac;
    int     cycles = 0;
    int     we_cnt = 0;

    // External memory and reference, key is {bank, addr}
    logic [7:0] ext_mem [logic [24:0]];
    logic [7:0] ref_mem [logic [24:0]];
    logic [7:0] mf2_ref [logic [12:0]];
    logic [255:0] map_ref = '0;
    logic en_ref = 1'b0, hid_ref = 1'b0, nmi_ref = 1'b0;
    logic [4:0] pen_ref;
    logic [3:0] crtc_ref;

    cpc_mem_top #(.EXP_BASE_PAGE(EXP_BASE), .REF_DIV(RDIV)) dut_i (.*);

    always #4 clk_48 = ~clk_48;   // 8 ns period

    // Unwritten bytes, every address bit counts
    function automatic logic [7:0] fill(input logic [24:0] k);
        return k[7:0] ^ k[15:8] ^ k[23:16] ^ {7'd0, k[24]} ^ 8'h5A;
    endfunction

    function automatic logic [7:0] ext_read(input logic [24:0] k);
        return ext_mem.exists(k) ? ext_mem[k] : fill(k);
    endfunction

    function automatic logic [7:0] ref_read(input logic [24:0] k);
        return ref_mem.exists(k) ? ref_mem[k] : fill(k);
    endfunction

    // ------------------------------
    // Memory model, no back-pressure
    // ------------------------------
    always @(posedge clk_48) begin
        if (sdram_we) begin
            ext_mem[{sdram_bank, sdram_addr}] = sdram_din;
            we_cnt++;
        end
        sdram_dout <= sdram_oe ? ext_read({sdram_bank, sdram_addr}) : 8'hFF;
    end

    always @(posedge clk_48) begin
        cycles++;
        if (cycles >= TIMEOUT) begin
            $display("ERROR: run did not finish within %0d cycles", TIMEOUT);
            $display("Simulation FAILED");
            $fatal(1, "timeout");
        end
    end

    task automatic fail_value(input string name, input logic [255:0] exp,
                              input logic [255:0] act);
        $display("ERROR: %s expected %0h actual %0h", name, exp, act);
        $display("Simulation FAILED");
        $fatal(1, "check failed");
    endtask

    // One download byte, then the minimum gap
    task automatic boot_byte(input logic [7:0] idx, input logic [24:0] a,
                             input logic [7:0] d, input bit expect_wr);
        int start;
        start = we_cnt;
        ioctl_index = idx;
        ioctl_addr  = a;
        ioctl_dout  = d;
        ioctl_wr    = 1'b1;
        @(negedge clk_48);
        ioctl_wr = 1'b0;
        repeat (2 * RDIV + 2) @(negedge clk_48);
        assert ((we_cnt != start) == expect_wr)
            else fail_value("boot_write_seen", expect_wr, we_cnt != start);
    endtask

    task automatic io_write(input logic [15:0] a, input logic [7:0] d);
        logic [12:0] sa;
        cpu_addr = a;
        cpu_dout = d;
        io_wr    = 1'b1;
        @(negedge clk_48);
        io_wr = 1'b0;
        @(negedge clk_48);
        if (a[15:2] == 14'h3FBA) begin
            if (!hid_ref) en_ref = ~a[1];   // FEE8 on, FEEA off
        end else begin
            sa = 13'h0000;
            case (a[15:8])
                8'h7F: case (d[7:6])
                    2'b00: begin
                        sa = 13'h1FCF;
                        pen_ref = d[4:0];
                    end
                    2'b01: sa = pen_ref[4] ? 13'h1FDF : 13'h1F90 + pen_ref[3:0];
                    2'b10: sa = 13'h1FEF;
                    default: sa = 13'h1FFF;
                endcase
                8'hBC: begin
                    sa = 13'h1CFF;
                    crtc_ref = d[3:0];
                end
                8'hBD: sa = 13'h1DB0 + crtc_ref;
                8'hF7: sa = 13'h17FF;
                8'hDF: sa = 13'h1AAC;
                default: sa = 13'h0000;
            endcase
            if (a[15:8] inside {8'h7F, 8'hBC, 8'hBD, 8'hF7, 8'hDF}) mf2_ref[sa] = d;
        end
    endtask

    task automatic mem_write(input logic [15:0] a, input logic [22:0] ra,
                             input logic [7:0] d);
        cpu_addr = a;
        ram_a    = ra;
        cpu_dout = d;
        mem_wr   = 1'b1;
        @(negedge clk_48);
        mem_wr = 1'b0;
        @(negedge clk_48);
        if (en_ref && a[15:13] == 3'b001) mf2_ref[a[12:0]] = d;
        else if (!(en_ref && a[15:13] == 3'b000)) ref_mem[{2'b00, ra}] = d;
    endtask

    task automatic mem_read(input string name, input logic [15:0] a,
                            input logic [22:0] ra);
        logic [7:0] exp;
        cpu_addr = a;
        ram_a    = ra;
        mem_rd   = 1'b1;
        repeat (3) @(negedge clk_48);   // RAM path is two cycles
        if (en_ref && a[15:13] == 3'b001) exp = mf2_ref[a[12:0]];
        else if (en_ref && a[15:13] == 3'b000) exp = ref_read({2'b00, PAGE_MF2, a[13:0]});
        else exp = ref_read({2'b00, ra});
        assert (cpu_din == exp) else fail_value(name, exp, cpu_din);
        mem_rd = 1'b0;
        @(negedge clk_48);
    endtask

    task automatic m1_fetch(input logic [15:0] a);
        cpu_addr = a;
        m1       = 1'b1;
        @(negedge clk_48);
        m1 = 1'b0;
        if (a == 16'h0066 && nmi_ref) begin
            en_ref  = 1'b1;
            hid_ref = 1'b0;
            nmi_ref = 1'b0;
        end else if (a == 16'h0065 && en_ref) begin
            hid_ref = 1'b1;
        end
        assert (mf2_nmi == nmi_ref) else fail_value("nmi_after_m1", nmi_ref, mf2_nmi);
        @(negedge clk_48);
    endtask

    initial begin
        logic [1:0]  sl;
        logic [7:0]  fp, d, idx;
        logic [13:0] off;
        logic [8:0]  pg;
        logic [15:0] pa;
        logic [12:0] wa;
        int          sel;

        RESET = 1'b1;
        ioctl_download = 1'b0;
        ioctl_wr = 1'b0;
        ioctl_addr = '0;
        ioctl_dout = '0;
        ioctl_index = '0;
        cpu_addr = '0;
        cpu_dout = '0;
        mem_rd = 1'b0;
        mem_wr = 1'b0;
        io_wr = 1'b0;
        m1 = 1'b0;
        key_nmi = 1'b0;
        ram_a = '0;
        sdram_dout = 8'hFF;
        repeat (5) @(negedge clk_48);
        RESET = 1'b0;
        @(negedge clk_48);

        // ------------------------------
        // System and expansion ROMs
        // ------------------------------
        ioctl_download = 1'b1;
        for (int i = 0; i < 24; i++) begin
            sl  = 2'($random(seed));
            off = 14'($random(seed));
            d   = 8'($random(seed));
            case (sl)
                2'd0: pg = PAGE_OS;
                2'd1: pg = PAGE_BASIC;
                2'd2: pg = PAGE_AMSDOS;
                default: pg = PAGE_MF2;
            endcase
            boot_byte(8'h00, {9'h000, sl, off}, d, 1'b1);
            ref_mem[{2'b00, pg, off}] = d;
        end
        for (int i = 0; i < 4; i++) begin
            boot_byte(8'h00, {9'h001 + 9'(i), 16'($random(seed))}, 8'($random(seed)), 1'b0);
        end
        for (int i = 0; i < 24; i++) begin
            idx = 8'd1 + 8'(($random(seed) & 32'h7fff_ffff) % 3);
            fp  = 8'($random(seed) & 32'h0000_0007);
            off = 14'($random(seed));
            d   = 8'($random(seed));
            boot_byte(idx, {3'b000, fp, off}, d, 1'b1);
            pg = EXP_BASE + {1'b0, fp};
            ref_mem[{2'b00, pg, off}] = d;
            ref_mem[{2'b01, pg, off}] = d;
            if (pg[8]) map_ref[pg[7:0]] = 1'b1;
        end
        ioctl_download = 1'b0;
        while (dut_i.boot_active) @(negedge clk_48);
        foreach (ref_mem[k]) begin
            assert (ext_read(k) == ref_mem[k]) else fail_value("rom_placement", ref_mem[k], ext_read(k));
        end
        assert (rom_map == map_ref) else fail_value("rom_map", map_ref, rom_map);

        // ------------------------------
        // CPU path, MF2 disabled
        // ------------------------------
        for (int i = 0; i < 60; i++) begin
            pa = 16'($random(seed));
            if ($random(seed) & 1) mem_write(pa, {15'h0040, 8'($random(seed))}, 8'($random(seed)));
            else mem_read("cpu_read", pa, {15'h0040, 8'($random(seed))});
        end
        d = ~ref_read({2'b00, PAGE_MF2, 14'h0100});
        mem_write(16'h8000, PROBE_A, d);   // Differs from the MF2 ROM byte

        // NMI and paging
        key_nmi = 1'b1;
        @(negedge clk_48);
        nmi_ref = 1'b1;
        assert (mf2_nmi == 1'b1) else fail_value("nmi_raise", 1, mf2_nmi);
        key_nmi = 1'b0;
        @(negedge clk_48);
        m1_fetch(16'h0066);
        mem_read("mf2_rom_read", 16'h0100, PROBE_A);
        mem_write(16'h0100, PROBE_A, d);   // ROM window, image must survive
        mem_read("rom_window_write", 16'h0100, PROBE_A);
        io_write(16'hFEEA, 8'h00);
        mem_read("disabled_read", 16'h0100, PROBE_A);

        // ------------------------------
        // Shadow stores and RAM window
        // ------------------------------
        io_write(16'hFEE8, 8'h00);
        io_write(16'h7F00, {3'b000, 5'($random(seed))});
        io_write(16'hBC00, 8'($random(seed)));
        for (int i = 0; i < 40; i++) begin
            sel = ($random(seed) & 32'h7fff_ffff) % 6;
            d   = 8'($random(seed));
            case (sel)
                0: io_write({8'h7F, 8'($random(seed))}, d);
                1: io_write({8'hBC, 8'($random(seed))}, d);
                2: io_write({8'hBD, 8'($random(seed))}, d);
                3: io_write({8'hF7, 8'($random(seed))}, d);
                4: io_write({8'hDF, 8'($random(seed))}, d);
                default: begin
                    wa = 13'($random(seed));
                    mem_write({3'b001, wa}, PROBE_A, d);
                end
            endcase
        end
        foreach (mf2_ref[a]) mem_read("mf2_window", {3'b001, a}, PROBE_A);
        io_write(16'hFEEA, 8'h00);
        foreach (mf2_ref[a]) mem_read("window_disabled", {3'b001, a}, {7'd0, 3'b001, a});

        // Hidden unit ignores port control
        io_write(16'hFEE8, 8'h00);
        m1_fetch(16'h0065);
        io_write(16'hFEEA, 8'h00);
        mem_read("hidden_stays_on", 16'h0100, PROBE_A);
        io_write(16'hFEE8, 8'h00);
        mem_read("hidden_unchanged", 16'h0100, PROBE_A);

        if (dut_i.assert_i.fail_cnt == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== sim/cpc_mem_assert.sv ====
`default_nettype none
`timescale 1ns/1ps

module cpc_mem_assert (
    input wire        clk_48,
    input wire        RESET,
    input wire        sdram_we,
    input wire        sdram_oe,
    input wire        boot_active,
    input wire        mf2_rom_en,
    input wire        mf2_nmi,
    input wire        m1,
    input wire [15:0] cpu_addr
);

    int fail_cnt = 0;   // Failed assertions so far

    // ------------------------------
    // Memory request sanity
    // ------------------------------
    we_oe_exclusive: assert property (@(posedge clk_48) disable iff (RESET)
        !(sdram_we && sdram_oe))
        else begin
            $error("sdram_we and sdram_oe high together");
            fail_cnt++;
        end

    // MF2 ROM is not backed by external writes
    no_rom_window_write: assert property (@(posedge clk_48) disable iff (RESET)
        (!boot_active && mf2_rom_en) |-> !sdram_we)
        else begin
            $error("external write inside MF2 ROM window");
            fail_cnt++;
        end

    // Vector fetch acknowledges the NMI
    nmi_cleared_on_vector: assert property (@(posedge clk_48) disable iff (RESET || boot_active)
        (mf2_nmi && $rose(m1) && cpu_addr == 16'h0066) |=> !mf2_nmi)
        else begin
            $error("mf2_nmi still set after M1 fetch at 0066");
            fail_cnt++;
        end

endmodule

bind cpc_mem_top cpc_mem_assert assert_i (
    .clk_48, .RESET, .sdram_we, .sdram_oe, .boot_active, .mf2_rom_en,
    .mf2_nmi, .m1, .cpu_addr
);

`default_nettype wire

// ==== hw/cpc_mem_top.sv ====
`default_nettype none
`timescale 1ns/1ps

module cpc_mem_top import cpc_pkg::*; #(
    parameter logic [8:0] EXP_BASE_PAGE = 9'h100,
    parameter int         REF_DIV       = 8
) (
    input  wire              clk_48,
    input  wire              RESET,
    // Download stream
    input  wire              ioctl_download,
    input  wire              ioctl_wr,
    input  wire [24:0]       ioctl_addr,
    input  wire [7:0]        ioctl_dout,
    input  wire [7:0]        ioctl_index,
    // CPU
    input  wire [15:0]       cpu_addr,
    input  wire [7:0]        cpu_dout,
    input  wire              mem_rd,
    input  wire              mem_wr,
    input  wire              io_wr,
    input  wire              m1,
    input  wire              key_nmi,
    input  wire [MEM_AW-1:0] ram_a,
    output wire [7:0]        cpu_din,
    output wire              mf2_nmi,
    // External memory
    output wire [MEM_AW-1:0] sdram_addr,
    output wire [1:0]        sdram_bank,
    output wire              sdram_we,
    output wire              sdram_oe,
    output wire [7:0]        sdram_din,
    input  wire [7:0]        sdram_dout,
    output wire [255:0]      rom_map
);

    // Loader to mux
    wire              boot_active;
    wire              boot_wr;
    wire [MEM_AW-1:0] boot_a;
    wire [1:0]        boot_bank;
    wire [7:0]        boot_dout;

    // Multiface to mux
    wire              mf2_ram_en;
    wire              mf2_rom_en;
    wire [7:0]        mf2_dout;

    rom_loader #(.EXP_BASE_PAGE(EXP_BASE_PAGE), .REF_DIV(REF_DIV)) loader_i (
        .clk_48, .RESET, .ioctl_download, .ioctl_wr, .ioctl_addr, .ioctl_dout,
        .ioctl_index, .boot_active, .boot_wr, .boot_a, .boot_bank, .boot_dout, .rom_map
    );

    mf2_unit mf2_i (
        .clk_48, .RESET, .boot_active, .cpu_addr, .cpu_dout, .mem_rd, .mem_wr,
        .io_wr, .m1, .key_nmi, .mf2_nmi, .mf2_ram_en, .mf2_rom_en, .mf2_dout
    );

    mem_mux mux_i (
        .boot_active, .boot_wr, .boot_a, .boot_bank, .boot_dout,
        .mf2_ram_en, .mf2_rom_en, .mf2_dout, .mem_rd, .mem_wr, .cpu_addr, .cpu_dout,
        .ram_a, .sdram_dout, .sdram_addr, .sdram_bank, .sdram_we, .sdram_oe,
        .sdram_din, .cpu_din
    );

endmodule

`default_nettype wire

// ==== hw/mem_mux.sv ====
`default_nettype none
`timescale 1ns/1ps

module mem_mux import cpc_pkg::*; (
    // Loader side
    input  wire               boot_active,
    input  wire               boot_wr,
    input  wire [MEM_AW-1:0]  boot_a,
    input  wire [1:0]         boot_bank,
    input  wire [7:0]         boot_dout,
    // Multiface side
    input  wire               mf2_ram_en,
    input  wire               mf2_rom_en,
    input  wire [7:0]         mf2_dout,
    // CPU side
    input  wire               mem_rd,
    input  wire               mem_wr,
    input  wire [15:0]        cpu_addr,
    input  wire [7:0]         cpu_dout,
    input  wire [MEM_AW-1:0]  ram_a,
    // External memory
    input  wire [7:0]         sdram_dout,
    output logic [MEM_AW-1:0] sdram_addr,
    output logic [1:0]        sdram_bank,
    output logic              sdram_we,
    output logic              sdram_oe,
    output logic [7:0]        sdram_din,
    output logic [7:0]        cpu_din
);

    logic [MEM_AW-1:0] cpu_mem_a;   // CPU address after MF2 ROM overlay

    assign cpu_mem_a = mf2_rom_en ? {PAGE_MF2, cpu_addr[13:0]} : ram_a;

    // ------------------------------
    // Request select
    // ------------------------------
    always_comb begin
        if (boot_active) begin
            sdram_addr = boot_a;
            sdram_bank = boot_bank;
            sdram_we   = boot_wr;
            sdram_oe   = 1'b0;            // No reads during load
            sdram_din  = boot_dout;
        end else begin
            sdram_addr = cpu_mem_a;
            sdram_bank = 2'b00;           // Single model, bank 0
            sdram_we   = mem_wr & ~mf2_ram_en & ~mf2_rom_en;  // MF2 windows are not backed here
            sdram_oe   = mem_rd & ~mf2_ram_en;
            sdram_din  = cpu_dout;
        end
    end

    // Idle sources drive FF
    assign cpu_din = sdram_dout & mf2_dout;

endmodule

`default_nettype wire

// ==== hw/mf2_unit.sv ====
`default_nettype none
`timescale 1ns/1ps

module mf2_unit import cpc_pkg::*; (
    input  wire        clk_48,
    input  wire        RESET,
    input  wire        boot_active,
    input  wire [15:0] cpu_addr,
    input  wire [7:0]  cpu_dout,
    input  wire        mem_rd,
    input  wire        mem_wr,
    input  wire        io_wr,
    input  wire        m1,
    input  wire        key_nmi,
    output logic       mf2_nmi,
    output logic       mf2_ram_en,
    output logic       mf2_rom_en,
    output logic [7:0] mf2_dout
);

    logic              mf2_en;
    logic              mf2_hidden;
    logic              old_key_nmi;
    logic              old_m1;
    logic              old_io_wr;
    logic              key_rise;
    logic              m1_rise;
    logic              io_rise;
    logic              ctrl_hit;     // FEE8 or FEEA
    logic              store_hit;    // Port shadowed in RAM
    logic              store_go;
    ga_word_u          ga_w;
    logic [4:0]        pen_index;
    logic [3:0]        crtc_reg;
    logic [MF2_AW-1:0] store_a;
    logic [MF2_AW-1:0] ram_addr;
    logic              ram_we;
    logic [7:0]        ram_in;
    logic [7:0]        ram_out;
    logic [7:0]        mf2_ram [2**MF2_AW];

    // ------------------------------
    // Edge detect
    // ------------------------------
    always_ff @(posedge clk_48) begin
        old_key_nmi <= key_nmi;
        old_m1      <= m1;
        old_io_wr   <= io_wr;
    end

    assign key_rise = key_nmi & ~old_key_nmi;
    assign m1_rise  = m1 & ~old_m1;
    assign io_rise  = io_wr & ~old_io_wr;

    // Windows only while paged in
    assign mf2_rom_en = mf2_en & (cpu_addr[15:13] == 3'b000);   // 0000-1FFF
    assign mf2_ram_en = mf2_en & (cpu_addr[15:13] == 3'b001);   // 2000-3FFF

    assign ctrl_hit = (cpu_addr[15:2] == 14'b1111_1110_1110_10);
    assign ga_w.raw = cpu_dout;
    assign store_go = io_rise & ~ctrl_hit & store_hit;

    // ------------------------------
    // Shadow address decode
    // ------------------------------
    always_comb begin
        store_hit = 1'b1;
        store_a   = '0;
        case (cpu_addr[15:8])
            8'h7F: begin
                case (ga_w.cmd.func)
                    GA_PEN:    store_a = 13'h1FCF;
                    GA_COLOUR: store_a = pen_index[4] ? 13'h1FDF : {9'h1F9, pen_index[3:0]};
                    GA_MODE:   store_a = 13'h1FEF;
                    GA_BANK:   store_a = 13'h1FFF;
                    default:   store_a = 13'h1FFF;
                endcase
            end
            8'hBC:   store_a = 13'h1CFF;             // CRTC select
            8'hBD:   store_a = {9'h1DB, crtc_reg};   // CRTC data per register
            8'hF7:   store_a = 13'h17FF;             // PPI control
            8'hDF:   store_a = 13'h1AAC;             // Upper ROM select
            default: store_hit = 1'b0;
        endcase
    end

    // ------------------------------
    // NMI and paging
    // ------------------------------
    always_ff @(posedge clk_48) begin
        if (RESET | boot_active) begin
            mf2_en     <= 1'b0;
            mf2_hidden <= 1'b0;
            mf2_nmi    <= 1'b0;
            ram_we     <= 1'b0;
        end else begin
            if (key_rise & ~mf2_en) begin
                mf2_nmi <= 1'b1;     // Freeze button
            end
            if (mf2_nmi & m1_rise & (cpu_addr == 16'h0066)) begin
                mf2_en     <= 1'b1;  // NMI vector fetch pages us in
                mf2_hidden <= 1'b0;
                mf2_nmi    <= 1'b0;
            end
            if (mf2_en & m1_rise & (cpu_addr == 16'h0065)) begin
                mf2_hidden <= 1'b1;
            end
            if (io_rise & ctrl_hit & ~mf2_hidden) begin
                mf2_en <= ~cpu_addr[1];  // FEE8 on, FEEA off
            end
            ram_we <= store_go | (mem_wr & mf2_ram_en);  // Shadow or CPU write
        end
    end

    // RAM address and data, shadow wins
    always_ff @(posedge clk_48) begin
        if (store_go) begin
            if ((cpu_addr[15:8] == 8'h7F) && (ga_w.cmd.func == GA_PEN)) begin
                pen_index <= ga_w.cmd.pen;
            end
            if (cpu_addr[15:8] == 8'hBC) begin
                crtc_reg <= cpu_dout[3:0];
            end
            ram_addr <= store_a;
            ram_in   <= ga_w.raw;
        end else begin
            ram_addr <= cpu_addr[MF2_AW-1:0];
            ram_in   <= cpu_dout;
        end
    end

    // ------------------------------
    // 8 KiB RAM
    // ------------------------------
    always_ff @(posedge clk_48) begin
        if (ram_we) begin
            mf2_ram[ram_addr] <= ram_in;
            ram_out           <= ram_in;   // Write-through
        end else begin
            ram_out <= mf2_ram[ram_addr];
        end
    end

    // FF lets the memory data through the AND
    assign mf2_dout = (mf2_ram_en & mem_rd) ? ram_out : 8'hFF;

endmodule

`default_nettype wire

// ==== hw/rom_loader.sv ====
`default_nettype none
`timescale 1ns/1ps

module rom_loader import cpc_pkg::*; #(
    parameter logic [8:0] EXP_BASE_PAGE = 9'h100,
    parameter int         REF_DIV       = 8
) (
    input  wire               clk_48,
    input  wire               RESET,
    input  wire               ioctl_download,
    input  wire               ioctl_wr,
    input  wire [24:0]        ioctl_addr,
    input  wire [7:0]         ioctl_dout,
    input  wire [7:0]         ioctl_index,
    output logic              boot_active,
    output logic              boot_wr,
    output logic [MEM_AW-1:0] boot_a,
    output logic [1:0]        boot_bank,
    output logic [7:0]        boot_dout,
    output logic [255:0]      rom_map
);

    localparam int CW = (REF_DIV > 1) ? $clog2(REF_DIV) : 1;

    logic [CW-1:0] ref_cnt;
    logic          ce_ref;        // One cycle in REF_DIV
    logic          rom_download;  // Index 0..3 only
    logic          old_download;
    logic          accept;
    logic          exp_file;      // Non-zero index
    logic          sys_hit;       // System byte below 64 KiB
    logic [8:0]    sys_page;
    logic [8:0]    exp_page;
    logic          boot_exp;      // Write in flight is expansion data
    logic          boot_dual;     // Bank-1 copy still owed

    // ------------------------------
    // Reference strobe
    // ------------------------------
    always_ff @(posedge clk_48) begin
        if (RESET) begin
            ref_cnt <= '0;
        end else if (ref_cnt == CW'(REF_DIV - 1)) begin
            ref_cnt <= '0;
        end else begin
            ref_cnt <= ref_cnt + 1'b1;
        end
    end

    assign ce_ref = (ref_cnt == '0);

    // ------------------------------
    // Download decode
    // ------------------------------
    assign rom_download = ioctl_download & (ioctl_index[4:0] < 5'd4);
    assign exp_file     = (ioctl_index != 8'h00);
    assign sys_hit      = (ioctl_addr[24:16] == 9'h000);
    assign accept       = rom_download & ioctl_wr & (exp_file | sys_hit);
    assign exp_page     = EXP_BASE_PAGE + {1'b0, ioctl_addr[21:14]};  // Base plus file page

    always_comb begin
        case (ioctl_addr[15:14])   // Slice within the 64 KiB image
            2'd0:    sys_page = PAGE_OS;
            2'd1:    sys_page = PAGE_BASIC;
            2'd2:    sys_page = PAGE_AMSDOS;
            default: sys_page = PAGE_MF2;
        endcase
    end

    // Control state
    always_ff @(posedge clk_48) begin
        if (RESET) begin
            boot_active  <= 1'b1;
            boot_wr      <= 1'b0;
            boot_exp     <= 1'b0;
            boot_dual    <= 1'b0;
            old_download <= 1'b0;
            rom_map      <= '0;
        end else begin
            old_download <= ioctl_download;
            if (rom_download) begin
                boot_active <= 1'b1;
            end else if (old_download & ~ioctl_download) begin
                boot_active <= 1'b0;   // Download just ended
            end

            if (accept) begin
                boot_wr   <= 1'b1;
                boot_exp  <= exp_file;
                // Second copy unless the first already lands in bank 1
                boot_dual <= exp_file & ~(&ioctl_index[7:6]) &
                             ((ioctl_index[7:6] == 2'b01) | (|ioctl_index[5:0]));
            end else if (ce_ref & boot_wr) begin
                if (boot_dual) begin
                    boot_dual <= 1'b0;          // Strobe stays up for bank 1
                end else begin
                    boot_wr <= 1'b0;
                    if (boot_exp & boot_a[22]) begin
                        rom_map[boot_a[21:14]] <= 1'b1;  // Upper-half page now holds a ROM
                    end
                end
            end
        end
    end

    // Write payload
    always_ff @(posedge clk_48) begin
        if (accept) begin
            boot_dout    <= ioctl_dout;
            boot_a[13:0] <= ioctl_addr[13:0];
            if (exp_file) begin
                boot_a[22:14] <= exp_page;
                boot_bank     <= {1'b0, &ioctl_index[7:6]};
            end else begin
                boot_a[22:14] <= sys_page;
                boot_bank     <= 2'd0;   // System ROMs in bank 0 only
            end
        end else if (ce_ref & boot_wr & boot_dual) begin
            boot_bank <= 2'd1;
        end
    end

endmodule

`default_nettype wire

// ==== hw/cpc_pkg.sv ====
`default_nettype none

package cpc_pkg;

    // ------------------------------
    // External memory
    // ------------------------------
    localparam int MEM_AW = 23;                 // Byte address into 8 MiB

    // 16 KiB system pages
    localparam logic [8:0] PAGE_OS     = 9'h000;
    localparam logic [8:0] PAGE_BASIC  = 9'h100;
    localparam logic [8:0] PAGE_AMSDOS = 9'h107;
    localparam logic [8:0] PAGE_MF2    = 9'h0FF;   // Multiface ROM image

    // ------------------------------
    // Multiface Two
    // ------------------------------
    localparam int MF2_AW = 13;                 // 8 KiB RAM

    // Gate-array function codes, top two data bits
    localparam logic [1:0] GA_PEN    = 2'b00;
    localparam logic [1:0] GA_COLOUR = 2'b01;
    localparam logic [1:0] GA_MODE   = 2'b10;
    localparam logic [1:0] GA_BANK   = 2'b11;

    // Command view of a port-7F byte
    typedef struct packed {
        logic [1:0] func;                       // One of GA_*
        logic       spare;
        logic [4:0] pen;                        // Bit 4 selects border
    } ga_cmd_t;

    // Same byte seen raw or as a command
    typedef union packed {
        logic [7:0] raw;
        ga_cmd_t    cmd;
    } ga_word_u;

endpackage

`default_nettype wire
